// File: source/cluster_cfg_pkg.sv
// cluster configuration package: bus widths, data types and the bus opcode
package cluster_cfg_pkg;

  // **********************************************************************
  // peripheral bus geometry
  // **********************************************************************
  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 32;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // wen high means read on this bus
  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } bus_op_e;

  // **********************************************************************
  // event sources
  // **********************************************************************
  // timer, dma, mailbox and one external line
  localparam int EVENT_NB = 4;

endpackage

// File: source/periph_map_pkg.sv
// peripheral address map: target field, register offsets and event bit positions
package periph_map_pkg;

  // **********************************************************************
  // address fields
  // **********************************************************************
  localparam int TARGET_LSB   = 10;
  localparam int OFFSET_LSB   = 2;
  localparam int OFFSET_WIDTH = 6;

  typedef enum logic [1:0] {
    TGT_CTRL  = 2'd0,
    TGT_TIMER = 2'd1,
    TGT_EVENT = 2'd2,
    TGT_NONE  = 2'd3
  } periph_target_e;

  // **********************************************************************
  // register word offsets
  // **********************************************************************
  // control unit
  localparam logic [OFFSET_WIDTH-1:0] CTRL_EOC       = 6'd0;
  localparam logic [OFFSET_WIDTH-1:0] CTRL_FETCH_EN  = 6'd2;
  localparam logic [OFFSET_WIDTH-1:0] CTRL_BOOT_ADDR = 6'd4;

  // timer
  localparam logic [OFFSET_WIDTH-1:0] TMR_CFG   = 6'd0;
  localparam logic [OFFSET_WIDTH-1:0] TMR_COUNT = 6'd1;
  localparam logic [OFFSET_WIDTH-1:0] TMR_CMP   = 6'd2;

  // event unit, core c mask sits at EVT_MASK_BASE + c
  localparam logic [OFFSET_WIDTH-1:0] EVT_PENDING   = 6'd0;
  localparam logic [OFFSET_WIDTH-1:0] EVT_CLEAR     = 6'd1;
  localparam logic [OFFSET_WIDTH-1:0] EVT_MASK_BASE = 6'd4;

  // bit positions in the pending register
  localparam int EVT_TIMER   = 0;
  localparam int EVT_DMA     = 1;
  localparam int EVT_MAILBOX = 2;
  localparam int EVT_EXT     = 3;

endpackage

// File: source/periph_decode.sv
// peripheral bus decoder: target strobes, word offset and pending response tracking
`timescale 1ns/1ps

module periph_decode
  import cluster_cfg_pkg::*;
  import periph_map_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    req_i,
  input  addr_t                   add_i,
  input  logic                    wen_i,
  output logic                    gnt_o,
  output logic                    ctrl_sel_o,
  output logic                    timer_sel_o,
  output logic                    event_sel_o,
  output logic [OFFSET_WIDTH-1:0] offset_o,
  output bus_op_e                 op_o,
  output periph_target_e          resp_target_o,
  output logic                    resp_valid_o
);

  periph_target_e target;

  // no back-pressure, every request is taken
  assign gnt_o = req_i;

  assign target   = periph_target_e'(add_i[TARGET_LSB +: $bits(periph_target_e)]);
  assign offset_o = add_i[OFFSET_LSB +: OFFSET_WIDTH];
  assign op_o     = wen_i ? OP_READ : OP_WRITE;

  // one strobe per mapped target, TGT_NONE raises none
  assign ctrl_sel_o  = req_i && (target == TGT_CTRL);
  assign timer_sel_o = req_i && (target == TGT_TIMER);
  assign event_sel_o = req_i && (target == TGT_EVENT);

  // response follows the accepted request by one cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_o  <= 1'b0;
      resp_target_o <= TGT_NONE;
    end else begin
      resp_valid_o <= req_i;
      if (req_i) begin
        resp_target_o <= target;
      end
    end
  end

endmodule

// File: source/cluster_ctrl_regs.sv
// cluster control unit: end of computation flag, per-core fetch enable and boot address
`timescale 1ns/1ps

module cluster_ctrl_regs
  import cluster_cfg_pkg::*;
  import periph_map_pkg::*;
#(
  parameter int    NB_CORES  = 4,
  parameter data_t BOOT_ADDR = 32'h1C00_0000
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    sel_i,
  input  logic [OFFSET_WIDTH-1:0] offset_i,
  input  bus_op_e                 op_i,
  input  data_t                   wdata_i,
  output data_t                   rdata_o,
  output logic                    eoc_o,
  output logic [NB_CORES-1:0]     fetch_enable_o,
  output data_t                   boot_addr_o
);

  logic  wr_en;
  data_t rd_data;

  assign wr_en = sel_i && (op_i == OP_WRITE);

  // **********************************************************************
  // register writes
  // **********************************************************************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      eoc_o          <= 1'b0;
      fetch_enable_o <= '0;
      boot_addr_o    <= BOOT_ADDR;
    end else if (wr_en) begin
      case (offset_i)
        // sticky, only reset brings it back down
        CTRL_EOC: begin
          if (wdata_i[0]) begin
            eoc_o <= 1'b1;
          end
        end
        CTRL_FETCH_EN:  fetch_enable_o <= wdata_i[NB_CORES-1:0];
        CTRL_BOOT_ADDR: boot_addr_o    <= wdata_i;
        default: ;
      endcase
    end
  end

  // **********************************************************************
  // read path
  // **********************************************************************
  always_comb begin
    rd_data = '0;
    case (offset_i)
      CTRL_EOC:       rd_data = data_t'(eoc_o);
      CTRL_FETCH_EN:  rd_data = data_t'(fetch_enable_o);
      CTRL_BOOT_ADDR: rd_data = boot_addr_o;
      default:        rd_data = '0;
    endcase
  end

  // read data captured on the strobe, valid in the response cycle
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_o <= rd_data;
    end
  end

endmodule

// File: source/cluster_timer.sv
// cluster timer: free-running counter with compare match event
`timescale 1ns/1ps

module cluster_timer
  import cluster_cfg_pkg::*;
  import periph_map_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    sel_i,
  input  logic [OFFSET_WIDTH-1:0] offset_i,
  input  bus_op_e                 op_i,
  input  data_t                   wdata_i,
  output data_t                   rdata_o,
  output logic                    event_o
);

  typedef enum logic {
    TMR_IDLE = 1'b0,
    TMR_RUN  = 1'b1
  } timer_state_e;

  timer_state_e state_q;
  data_t        count_q;
  data_t        cmp_q;
  logic         cfg_wr;
  logic         match;
  data_t        rd_data;

  assign cfg_wr = sel_i && (op_i == OP_WRITE) && (offset_i == TMR_CFG);
  assign match  = (state_q == TMR_RUN) && (count_q == cmp_q);

  // **********************************************************************
  // state, compare value and counter
  // **********************************************************************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= TMR_IDLE;
      cmp_q   <= '0;
      count_q <= '0;
      event_o <= 1'b0;
    end else begin
      if (cfg_wr) begin
        state_q <= wdata_i[0] ? TMR_RUN : TMR_IDLE;
      end
      if (sel_i && (op_i == OP_WRITE) && (offset_i == TMR_CMP)) begin
        cmp_q <= wdata_i;
      end
      // clear request beats the running count
      if (cfg_wr && wdata_i[1]) begin
        count_q <= '0;
      end else if (match) begin
        count_q <= '0;
      end else if (state_q == TMR_RUN) begin
        count_q <= count_q + 1'b1;
      end
      event_o <= match;
    end
  end

  always_comb begin
    case (offset_i)
      TMR_CFG:   rd_data = data_t'(state_q == TMR_RUN);
      TMR_COUNT: rd_data = count_q;
      TMR_CMP:   rd_data = cmp_q;
      default:   rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_o <= rd_data;
    end
  end

endmodule

// File: source/event_irq_unit.sv
// event unit: pending event latch, per-core masks and interrupt requests
`timescale 1ns/1ps

module event_irq_unit
  import cluster_cfg_pkg::*;
  import periph_map_pkg::*;
#(
  parameter int NB_CORES = 4
) (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    sel_i,
  input  logic [OFFSET_WIDTH-1:0] offset_i,
  input  bus_op_e                 op_i,
  input  data_t                   wdata_i,
  input  logic                    timer_evt_i,
  input  logic                    dma_evt_i,
  input  logic                    mailbox_evt_i,
  input  logic                    ext_evt_i,
  output data_t                   rdata_o,
  output logic [NB_CORES-1:0]     irq_req_o
);

  logic [EVENT_NB-1:0] evt_src;
  logic [EVENT_NB-1:0] pending_q;
  logic [EVENT_NB-1:0] clr_mask;
  logic [EVENT_NB-1:0] mask_q [NB_CORES];
  logic                wr_en;
  data_t               rd_data;

  assign wr_en = sel_i && (op_i == OP_WRITE);

  always_comb begin
    evt_src              = '0;
    evt_src[EVT_TIMER]   = timer_evt_i;
    evt_src[EVT_DMA]     = dma_evt_i;
    evt_src[EVT_MAILBOX] = mailbox_evt_i;
    evt_src[EVT_EXT]     = ext_evt_i;
  end

  // write one to clear
  assign clr_mask = (wr_en && (offset_i == EVT_CLEAR)) ? wdata_i[EVENT_NB-1:0] : '0;

  // **********************************************************************
  // pending and mask registers
  // **********************************************************************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      for (int c = 0; c < NB_CORES; c++) begin
        mask_q[c] <= '0;
      end
    end else begin
      // a new event wins over a clear in the same cycle
      pending_q <= (pending_q & ~clr_mask) | evt_src;
      for (int c = 0; c < NB_CORES; c++) begin
        if (wr_en && (offset_i == OFFSET_WIDTH'(EVT_MASK_BASE + c))) begin
          mask_q[c] <= wdata_i[EVENT_NB-1:0];
        end
      end
    end
  end

  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      irq_req_o[c] = |(pending_q & mask_q[c]);
    end
  end

  // clear register reads back as zero
  always_comb begin
    rd_data = '0;
    if (offset_i == EVT_PENDING) begin
      rd_data = data_t'(pending_q);
    end
    for (int c = 0; c < NB_CORES; c++) begin
      if (offset_i == OFFSET_WIDTH'(EVT_MASK_BASE + c)) begin
        rd_data = data_t'(mask_q[c]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_o <= rd_data;
    end
  end

endmodule

// File: source/periph_response.sv
// response stage: selects the addressed target's read data and drives r_valid
`timescale 1ns/1ps

module periph_response
  import cluster_cfg_pkg::*;
  import periph_map_pkg::*;
(
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  periph_target_e resp_target_i,
  input  logic           resp_valid_i,
  input  data_t          ctrl_rdata_i,
  input  data_t          timer_rdata_i,
  input  data_t          event_rdata_i,
  input  bus_op_e        op_resp_i,
  output logic           r_valid_o,
  output data_t          r_rdata_o
);

  bus_op_e op_q;
  data_t   sel_rdata;

  // opcode of the request being answered
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      op_q <= OP_READ;
    end else begin
      op_q <= op_resp_i;
    end
  end

  always_comb begin
    case (resp_target_i)
      TGT_CTRL:  sel_rdata = ctrl_rdata_i;
      TGT_TIMER: sel_rdata = timer_rdata_i;
      TGT_EVENT: sel_rdata = event_rdata_i;
      default:   sel_rdata = '0;
    endcase
  end

  assign r_valid_o = resp_valid_i;
  assign r_rdata_o = (resp_valid_i && (op_q == OP_READ)) ? sel_rdata : '0;

endmodule

// File: source/cluster_periph_top.sv
// cluster peripheral block: bus decode, control unit, timer, event unit and response
`timescale 1ns/1ps

module cluster_periph_top
  import cluster_cfg_pkg::*;
  import periph_map_pkg::*;
#(
  parameter int    NB_CORES  = 4,
  parameter data_t BOOT_ADDR = 32'h1C00_0000
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // peripheral slave bus
  input  logic                req_i,
  input  addr_t               add_i,
  input  logic                wen_i,
  input  data_t               wdata_i,
  output logic                gnt_o,
  output logic                r_valid_o,
  output data_t               r_rdata_o,
  // event sources
  input  logic                dma_evt_i,
  input  logic                mailbox_evt_i,
  input  logic                ext_evt_i,
  output logic                eoc_o,
  output logic [NB_CORES-1:0] fetch_enable_o,
  output data_t               boot_addr_o,
  output logic [NB_CORES-1:0] irq_req_o
);

  logic                    ctrl_sel, timer_sel, event_sel;
  logic [OFFSET_WIDTH-1:0] offset;
  bus_op_e                 op;
  periph_target_e          resp_target;
  logic                    resp_valid;
  data_t                   ctrl_rdata, timer_rdata, event_rdata;
  logic                    timer_evt;

  // **********************************************************************
  // decode
  // **********************************************************************
  periph_decode u_decode (
    .clk_i, .arst_n_i, .req_i, .add_i, .wen_i, .gnt_o,
    .ctrl_sel_o    ( ctrl_sel    ),
    .timer_sel_o   ( timer_sel   ),
    .event_sel_o   ( event_sel   ),
    .offset_o      ( offset      ),
    .op_o          ( op          ),
    .resp_target_o ( resp_target ),
    .resp_valid_o  ( resp_valid  )
  );

  // **********************************************************************
  // targets
  // **********************************************************************
  cluster_ctrl_regs #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) u_ctrl (
    .clk_i, .arst_n_i, .wdata_i, .eoc_o, .fetch_enable_o, .boot_addr_o,
    .sel_i    ( ctrl_sel   ),
    .offset_i ( offset     ),
    .op_i     ( op         ),
    .rdata_o  ( ctrl_rdata )
  );

  cluster_timer u_timer (
    .clk_i, .arst_n_i, .wdata_i,
    .sel_i    ( timer_sel   ),
    .offset_i ( offset      ),
    .op_i     ( op          ),
    .rdata_o  ( timer_rdata ),
    .event_o  ( timer_evt   )
  );

  event_irq_unit #(
    .NB_CORES ( NB_CORES )
  ) u_event (
    .clk_i, .arst_n_i, .wdata_i, .dma_evt_i, .mailbox_evt_i, .ext_evt_i, .irq_req_o,
    .sel_i       ( event_sel   ),
    .offset_i    ( offset      ),
    .op_i        ( op          ),
    .timer_evt_i ( timer_evt   ),
    .rdata_o     ( event_rdata )
  );

  // **********************************************************************
  // response
  // **********************************************************************
  periph_response u_response (
    .clk_i, .arst_n_i, .r_valid_o, .r_rdata_o,
    .resp_target_i ( resp_target ),
    .resp_valid_i  ( resp_valid  ),
    .ctrl_rdata_i  ( ctrl_rdata  ),
    .timer_rdata_i ( timer_rdata ),
    .event_rdata_i ( event_rdata ),
    .op_resp_i     ( op          )
  );

endmodule

// File: bench/cluster_periph_checker.sv
// cluster peripheral protocol checker: grant, response timing, sticky eoc and reset state
`timescale 1ns/1ps

module cluster_periph_checker #(
  parameter int NB_CORES = 4
) (
  input logic                clk_i,
  input logic                arst_n_i,
  input logic                req_i,
  input logic                gnt_i,
  input logic                r_valid_i,
  input logic                eoc_i,
  input logic [NB_CORES-1:0] irq_req_i
);

  int unsigned fail_cnt = 0;

  // no back-pressure on this bus
  gnt_equals_req: assert property (@(posedge clk_i) disable iff (!arst_n_i) gnt_i == req_i)
    else begin
      $error("gnt_o differs from req_i");
      fail_cnt++;
    end

  resp_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i) req_i |=> r_valid_i)
    else begin
      $error("r_valid_o missing one cycle after an accepted request");
      fail_cnt++;
    end

  no_spurious_resp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !req_i |=> !r_valid_i)
    else begin
      $error("r_valid_o raised without a request");
      fail_cnt++;
    end

  // eoc is sticky until reset
  eoc_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i) !$fell(eoc_i))
    else begin
      $error("eoc_o fell outside reset");
      fail_cnt++;
    end

  quiet_in_reset: assert property (@(posedge clk_i)
    !arst_n_i |-> (!r_valid_i && (irq_req_i == '0)))
    else begin
      $error("r_valid_o or irq_req_o active during reset");
      fail_cnt++;
    end

endmodule

bind cluster_periph_top cluster_periph_checker #(
  .NB_CORES ( NB_CORES )
) u_checker (
  .clk_i,
  .arst_n_i,
  .req_i,
  .gnt_i     ( gnt_o     ),
  .r_valid_i ( r_valid_o ),
  .eoc_i     ( eoc_o     ),
  .irq_req_i ( irq_req_o )
);

// File: bench/cluster_periph_tb.sv
// cluster peripheral testbench: bus accesses checked against a register model
`timescale 1ns/1ps

module cluster_periph_tb
  import cluster_cfg_pkg::*;
  import periph_map_pkg::*;
();

  localparam int    NB_CORES       = 4;
  localparam data_t BOOT_ADDR      = 32'h1C00_0000;
  localparam int    TIMEOUT_CYCLES = 3000;

  logic                clk_i;
  logic                arst_n_i;
  logic                req_i;
  addr_t               add_i;
  logic                wen_i;
  data_t               wdata_i;
  logic                gnt_o;
  logic                r_valid_o;
  data_t               r_rdata_o;
  logic                dma_evt_i;
  logic                mailbox_evt_i;
  logic                ext_evt_i;
  logic                eoc_o;
  logic [NB_CORES-1:0] fetch_enable_o;
  data_t               boot_addr_o;
  logic [NB_CORES-1:0] irq_req_o;

  // register model
  logic                m_eoc;
  logic [NB_CORES-1:0] m_fetch_en;
  data_t               m_boot;
  logic                m_tmr_run;
  data_t               m_tmr_cmp;
  logic [EVENT_NB-1:0] m_pending;
  logic [EVENT_NB-1:0] m_mask [NB_CORES];

  data_t exp_q [$];
  int    resp_cnt;
  int    err_cnt;
  int    test_err_base;
  int    tests_run;
  int    tests_failed;
  int    cycle_cnt = 0;

  cluster_periph_top #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // **********************************************************************
  // reference model
  // **********************************************************************
  function automatic data_t ref_rdata(input logic [1:0] tgt,
                                      input logic [OFFSET_WIDTH-1:0] off);
    data_t val;
    val = '0;
    case (tgt)
      TGT_CTRL: begin
        case (off)
          CTRL_EOC:       val = data_t'(m_eoc);
          CTRL_FETCH_EN:  val = data_t'(m_fetch_en);
          CTRL_BOOT_ADDR: val = m_boot;
          default:        val = '0;
        endcase
      end
      TGT_TIMER: begin
        if (off == TMR_CFG) val = data_t'(m_tmr_run);
        if (off == TMR_CMP) val = m_tmr_cmp;
      end
      TGT_EVENT: begin
        if (off == EVT_PENDING) val = data_t'(m_pending);
        if (off >= EVT_MASK_BASE && off < EVT_MASK_BASE + NB_CORES) begin
          val = data_t'(m_mask[off - EVT_MASK_BASE]);
        end
      end
      default: val = '0;
    endcase
    return val;
  endfunction

  function automatic void model_write(input logic [1:0] tgt,
                                      input logic [OFFSET_WIDTH-1:0] off, input data_t data);
    case (tgt)
      TGT_CTRL: begin
        if (off == CTRL_EOC && data[0]) m_eoc = 1'b1;
        if (off == CTRL_FETCH_EN) m_fetch_en = data[NB_CORES-1:0];
        if (off == CTRL_BOOT_ADDR) m_boot = data;
      end
      TGT_TIMER: begin
        if (off == TMR_CFG) m_tmr_run = data[0];
        if (off == TMR_CMP) m_tmr_cmp = data;
      end
      TGT_EVENT: begin
        if (off == EVT_CLEAR) m_pending = m_pending & ~data[EVENT_NB-1:0];
        for (int c = 0; c < NB_CORES; c++) begin
          if (off == EVT_MASK_BASE + c) m_mask[c] = data[EVENT_NB-1:0];
        end
      end
      default: ;
    endcase
  endfunction

  // a core requests when any unmasked pending bit is set
  function automatic logic [NB_CORES-1:0] expected_irq();
    logic [NB_CORES-1:0] irq;
    for (int c = 0; c < NB_CORES; c++) begin
      irq[c] = |(m_pending & m_mask[c]);
    end
    return irq;
  endfunction

  function automatic int total_errors();
    return err_cnt + int'(dut.u_checker.fail_cnt);
  endfunction

  // **********************************************************************
  // bus master
  // **********************************************************************
  task automatic bus_access(input logic [1:0] tgt, input logic [OFFSET_WIDTH-1:0] off,
                            input logic is_read, input data_t data);
    int start;
    int waited;
    start = resp_cnt;
    exp_q.push_back(is_read ? ref_rdata(tgt, off) : data_t'(0));
    if (!is_read) model_write(tgt, off, data);
    @(posedge clk_i);
    req_i   <= 1'b1;
    add_i   <= (addr_t'(tgt) << TARGET_LSB) | (addr_t'(off) << OFFSET_LSB);
    wen_i   <= is_read;
    wdata_i <= data;
    @(posedge clk_i);
    req_i <= 1'b0;
    waited = 0;
    while (resp_cnt == start && waited < 4) begin
      @(posedge clk_i);
      waited++;
    end
    assert (resp_cnt != start) else begin
      $display("no r_valid_o for the access to target %0d offset %0d", tgt, off);
      err_cnt++;
      exp_q.delete();
    end
  endtask

  task automatic write_reg(input logic [1:0] tgt, input logic [OFFSET_WIDTH-1:0] off,
                           input data_t data);
    bus_access(tgt, off, 1'b0, data);
  endtask

  task automatic read_reg(input logic [1:0] tgt, input logic [OFFSET_WIDTH-1:0] off);
    bus_access(tgt, off, 1'b1, '0);
  endtask

  task automatic read_model_regs();
    read_reg(TGT_CTRL, CTRL_EOC);
    read_reg(TGT_CTRL, CTRL_FETCH_EN);
    read_reg(TGT_CTRL, CTRL_BOOT_ADDR);
    read_reg(TGT_TIMER, TMR_CFG);
    read_reg(TGT_TIMER, TMR_CMP);
    read_reg(TGT_EVENT, EVT_PENDING);
    for (int c = 0; c < NB_CORES; c++) begin
      read_reg(TGT_EVENT, OFFSET_WIDTH'(EVT_MASK_BASE + c));
    end
  endtask

  // one-cycle pulse on the external sources with the timer bit ignored
  task automatic pulse_events(input logic [EVENT_NB-1:0] bits);
    @(posedge clk_i);
    dma_evt_i     <= bits[EVT_DMA];
    mailbox_evt_i <= bits[EVT_MAILBOX];
    ext_evt_i     <= bits[EVT_EXT];
    @(posedge clk_i);
    dma_evt_i     <= 1'b0;
    mailbox_evt_i <= 1'b0;
    ext_evt_i     <= 1'b0;
    m_pending = m_pending | (bits & ~(EVENT_NB'(1) << EVT_TIMER));
  endtask

  task automatic check_irq();
    @(negedge clk_i);
    assert (irq_req_o === expected_irq()) else begin
      $display("mismatch irq_req_o: got %h expected %h", irq_req_o, expected_irq());
      err_cnt++;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (total_errors() == test_err_base) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, total_errors() - test_err_base);
    end
    test_err_base = total_errors();
  endtask

  // **********************************************************************
  // response comparison
  // **********************************************************************
  always @(negedge clk_i) begin : compare_responses
    data_t exp_data;
    if (arst_n_i && r_valid_o) begin
      resp_cnt++;
      assert (exp_q.size() != 0) else begin
        $display("r_valid_o arrived with no access outstanding");
        err_cnt++;
      end
      if (exp_q.size() != 0) begin
        exp_data = exp_q.pop_front();
        assert (r_rdata_o === exp_data) else begin
          $display("mismatch r_rdata_o: got %h expected %h", r_rdata_o, exp_data);
          err_cnt++;
        end
      end
      assert (eoc_o === m_eoc) else begin
        $display("mismatch eoc_o: got %h expected %h", eoc_o, m_eoc);
        err_cnt++;
      end
      assert (fetch_enable_o === m_fetch_en) else begin
        $display("mismatch fetch_enable_o: got %h expected %h", fetch_enable_o, m_fetch_en);
        err_cnt++;
      end
      assert (boot_addr_o === m_boot) else begin
        $display("mismatch boot_addr_o: got %h expected %h", boot_addr_o, m_boot);
        err_cnt++;
      end
    end
  end

  // **********************************************************************
  // test sequence
  // **********************************************************************
  initial begin
    data_t                   data;
    logic [1:0]              tgt;
    logic [OFFSET_WIDTH-1:0] off;
    logic [EVENT_NB-1:0]     bits;
    int                      kind;
    int                      waited;
    void'($urandom(49));
    arst_n_i      = 1'b0;
    req_i         = 1'b0;
    add_i         = '0;
    wen_i         = 1'b0;
    wdata_i       = '0;
    dma_evt_i     = 1'b0;
    mailbox_evt_i = 1'b0;
    ext_evt_i     = 1'b0;
    m_eoc         = 1'b0;
    m_fetch_en    = '0;
    m_boot        = BOOT_ADDR;
    m_tmr_run     = 1'b0;
    m_tmr_cmp     = '0;
    m_pending     = '0;
    for (int c = 0; c < NB_CORES; c++) begin
      m_mask[c] = '0;
    end
    resp_cnt      = 0;
    err_cnt       = 0;
    test_err_base = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;

    read_model_regs();
    check_irq();
    end_test("reset values");

    repeat (40) begin
      kind = $urandom_range(3, 0);
      data = $urandom();
      tgt  = TGT_CTRL;
      off  = CTRL_FETCH_EN;
      if (kind == 1) begin
        off = CTRL_BOOT_ADDR;
      end else if (kind == 2) begin
        tgt = TGT_TIMER;
        off = TMR_CMP;
      end else if (kind == 3) begin
        tgt = TGT_EVENT;
        off = OFFSET_WIDTH'(EVT_MASK_BASE + $urandom_range(NB_CORES - 1, 0));
      end
      write_reg(tgt, off, data);
      read_reg(tgt, off);
    end
    end_test("random read back");

    // offsets 8 and up are unused by every target
    repeat (12) begin
      tgt = 2'($urandom_range(3, 0));
      off = OFFSET_WIDTH'($urandom_range(63, 8));
      if ($urandom_range(1, 0) == 1) begin
        tgt = TGT_NONE;
        off = OFFSET_WIDTH'($urandom_range(63, 0));
      end
      write_reg(tgt, off, $urandom());
      read_reg(tgt, off);
    end
    read_model_regs();
    end_test("unmapped and unknown");

    data = $urandom_range(8, 3);
    write_reg(TGT_EVENT, OFFSET_WIDTH'(EVT_MASK_BASE + 1), 1 << EVT_TIMER);
    write_reg(TGT_TIMER, TMR_CMP, data);
    write_reg(TGT_TIMER, TMR_CFG, 32'h3);
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!irq_req_o[1] && waited < data + 10);
    assert (irq_req_o[1]) else begin
      $display("timer match did not raise irq_req_o[1] within %0d cycles", data + 10);
      err_cnt++;
    end
    m_pending[EVT_TIMER] = 1'b1;
    read_reg(TGT_EVENT, EVT_PENDING);
    write_reg(TGT_TIMER, TMR_CFG, 32'h0);
    // a match on the disabling edge still lands in pending
    idle_cycles(4);
    write_reg(TGT_EVENT, EVT_CLEAR, 1 << EVT_TIMER);
    check_irq();
    read_reg(TGT_EVENT, EVT_PENDING);
    end_test("timer event");

    repeat (6) begin
      for (int c = 0; c < NB_CORES; c++) begin
        write_reg(TGT_EVENT, OFFSET_WIDTH'(EVT_MASK_BASE + c), $urandom_range(15, 0));
      end
      bits = EVENT_NB'($urandom_range(7, 1)) << 1;
      pulse_events(bits);
      check_irq();
      read_reg(TGT_EVENT, EVT_PENDING);
      write_reg(TGT_EVENT, EVT_CLEAR, $urandom_range(15, 0));
      read_reg(TGT_EVENT, EVT_PENDING);
      check_irq();
    end
    end_test("external events and masking");

    write_reg(TGT_CTRL, CTRL_EOC, 32'h1);
    write_reg(TGT_CTRL, CTRL_EOC, 32'h0);
    read_reg(TGT_CTRL, CTRL_EOC);
    end_test("end of computation");

    idle_cycles(2);
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: verilog.f
source/cluster_cfg_pkg.sv
source/periph_map_pkg.sv
source/periph_decode.sv
source/cluster_ctrl_regs.sv
source/cluster_timer.sv
source/event_irq_unit.sv
source/periph_response.sv
source/cluster_periph_top.sv
bench/cluster_periph_checker.sv
bench/cluster_periph_tb.sv
